// ==== src/huff_config.svh ====
`ifndef HUFF_CONFIG_SVH
`define HUFF_CONFIG_SVH

//////////////////////////////////////////////////////////////////////
// tree sizes

`define HUFF_NUM_LEAVES 10 // input weights take ids 0..9
`define HUFF_NUM_NODES  18 // leaves plus stored internal nodes
`define HUFF_NUM_MERGES 9  // last one is the root

//////////////////////////////////////////////////////////////////////
// widths

`define HUFF_WEIGHT_W 8
`define HUFF_SUM_W    12 // ten 8-bit weights never overflow this
`define HUFF_ID_W     5

`endif

// ==== src/huff_pkg.sv ====
`include "huff_config.svh"

package huff_pkg;

    typedef logic [`HUFF_WEIGHT_W-1:0] weight_t;
    typedef logic [`HUFF_SUM_W-1:0]    nodeWeight_t;
    typedef logic [`HUFF_ID_W-1:0]     nodeId_t;

    // leaf[i] belongs to node id i
    typedef struct packed {
        weight_t [`HUFF_NUM_LEAVES-1:0] leaf;
    } leafWeights_t;

    // one merge with the parent id in the top bits
    typedef struct packed {
        nodeId_t parent;
        nodeId_t left;
        nodeId_t right;
    } treeEntry_t;

    // root merge is not stored here
    typedef treeEntry_t [`HUFF_NUM_MERGES-2:0] treeTable_t;

    typedef struct packed {
        nodeId_t     id;
        nodeWeight_t weight;
        logic        valid; // low when nothing is left to pick
    } pick_t;

    typedef enum logic [1:0] {
        IDLE,
        PICK_RIGHT,
        PICK_LEFT,
        MERGE
    } ctrlState_t;

endpackage

// ==== src/huffTreeCtrl.sv ====
module huffTreeCtrl (
    input  logic Clk_in,
    input  logic n_Rst,
    input  logic Start,
    input  logic LastMerge,
    output logic LoadPool,
    output logic MarkUsed,
    output logic TakeRight,
    output logic TakeLeft,
    output logic WriteNode,
    output logic CountClr,
    output logic CountStep,
    output logic Busy,
    output logic Done
);

    huff_pkg::ctrlState_t state;
    huff_pkg::ctrlState_t nextState;
    logic                 startOk;

    // Busy lags the state by one edge, so it is still high for the
    // first idle cycle after the root merge
    assign startOk = (state == huff_pkg::IDLE) && Start && !Busy;

    always_comb
    begin
        nextState = state;
        case (state)
            huff_pkg::IDLE:
            begin
                if (startOk)
                    nextState = huff_pkg::PICK_RIGHT;
            end
            huff_pkg::PICK_RIGHT: nextState = huff_pkg::PICK_LEFT;
            huff_pkg::PICK_LEFT:  nextState = huff_pkg::MERGE;
            huff_pkg::MERGE:
            begin
                if (LastMerge)
                    nextState = huff_pkg::IDLE; // root written
                else
                    nextState = huff_pkg::PICK_RIGHT;
            end
            default: nextState = huff_pkg::IDLE;
        endcase
    end

    always_ff @(posedge Clk_in or negedge n_Rst)
    begin
        if (!n_Rst)
        begin
            state <= huff_pkg::IDLE;
            Busy  <= 1'b0;
            Done  <= 1'b0;
        end
        else
        begin
            state <= nextState;
            Busy  <= (state != huff_pkg::IDLE);
            Done  <= Busy && (state == huff_pkg::IDLE); // first idle cycle only
        end
    end

    //////////////////////////////////////////////////////////////////////
    // strobes decoded from the current state

    assign LoadPool  = startOk;
    assign CountClr  = startOk;
    assign TakeRight = (state == huff_pkg::PICK_RIGHT);
    assign TakeLeft  = (state == huff_pkg::PICK_LEFT);
    assign MarkUsed  = TakeRight || TakeLeft; // retire whichever was picked
    assign WriteNode = (state == huff_pkg::MERGE);
    assign CountStep = (state == huff_pkg::MERGE);

endmodule

// ==== src/mergeCounter.sv ====
`include "huff_config.svh"

module mergeCounter (
    input  logic              Clk_in,
    input  logic              n_Rst,
    input  logic              CountClr,
    input  logic              CountStep,
    output huff_pkg::nodeId_t NewId,
    output logic              LastMerge
);

    logic [3:0] mergeCount; // 0..8

    always_ff @(posedge Clk_in or negedge n_Rst)
    begin
        if (!n_Rst)
            mergeCount <= 4'd0;
        else if (CountClr)
            mergeCount <= 4'd0;
        else if (CountStep && !LastMerge)
            mergeCount <= mergeCount + 4'd1;
        // holds at 8 after the root merge
    end

    // new nodes follow the leaves as ids 10..18
    assign NewId = huff_pkg::nodeId_t'(`HUFF_NUM_LEAVES) + {1'b0, mergeCount};

    assign LastMerge = (mergeCount == 4'(`HUFF_NUM_MERGES - 1));

endmodule

// ==== src/weightPool.sv ====
`include "huff_config.svh"

module weightPool (
    input  logic                                          Clk_in,
    input  logic                                          n_Rst,
    input  logic                                          LoadPool,
    input  logic                                          MarkUsed,
    input  logic                                          WriteNode,
    input  huff_pkg::leafWeights_t                        Weights,
    input  huff_pkg::pick_t                               Pick,
    input  huff_pkg::nodeId_t                             NewId,
    input  huff_pkg::nodeWeight_t                         PickedSum,
    output huff_pkg::nodeWeight_t [`HUFF_NUM_NODES-1:0]   NodeWeights,
    output logic [`HUFF_NUM_NODES-1:0]                    Used
);

    logic storeNode;

    // the root sum lands on id 18, which has no slot
    assign storeNode = WriteNode && (NewId < huff_pkg::nodeId_t'(`HUFF_NUM_NODES));

    //////////////////////////////////////////////////////////////////////
    // node weights

    always_ff @(posedge Clk_in)
    begin
        if (LoadPool)
        begin
            for (int i = 0; i < `HUFF_NUM_LEAVES; i++)
            begin
                NodeWeights[i] <= huff_pkg::nodeWeight_t'(Weights.leaf[i]);
            end
        end
        else if (storeNode)
        begin
            NodeWeights[NewId] <= PickedSum;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // availability
    // a set bit means the node can't be picked, either merged already
    // or not yet written

    always_ff @(posedge Clk_in or negedge n_Rst)
    begin
        if (!n_Rst)
        begin
            Used <= '1; // nothing to pick before the first load
        end
        else if (LoadPool)
        begin
            for (int i = 0; i < `HUFF_NUM_NODES; i++)
            begin
                Used[i] <= (i >= `HUFF_NUM_LEAVES); // internal nodes absent
            end
        end
        else if (MarkUsed && Pick.valid)
        begin
            Used[Pick.id] <= 1'b1;
        end
        else if (storeNode)
        begin
            Used[NewId] <= 1'b0; // new node joins the pool
        end
    end

endmodule

// ==== src/minFinder.sv ====
`include "huff_config.svh"

module minFinder (
    input  huff_pkg::nodeWeight_t [`HUFF_NUM_NODES-1:0] Weights,
    input  logic [`HUFF_NUM_NODES-1:0]                  Used,
    output huff_pkg::pick_t                             Pick
);

    huff_pkg::pick_t best;

    //////////////////////////////////////////////////////////////////////
    // linear scan from id 0 upward

    always_comb
    begin
        best.id     = '0;
        best.weight = '0;
        best.valid  = 1'b0;
        for (int i = 0; i < `HUFF_NUM_NODES; i++)
        begin
            // strict compare keeps the lower id on a tie
            if (!Used[i] && (!best.valid || (Weights[i] < best.weight)))
            begin
                best.id     = huff_pkg::nodeId_t'(i);
                best.weight = Weights[i];
                best.valid  = 1'b1;
            end
        end
    end

    assign Pick = best;

endmodule

// ==== src/treeTable.sv ====
`include "huff_config.svh"

module treeTable (
    input  logic                  Clk_in,
    input  logic                  n_Rst,
    input  logic                  LoadPool,
    input  logic                  TakeRight,
    input  logic                  TakeLeft,
    input  logic                  WriteNode,
    input  huff_pkg::pick_t       Pick,
    input  huff_pkg::nodeId_t     NewId,
    input  logic                  LastMerge,
    output huff_pkg::nodeWeight_t PickedSum,
    output huff_pkg::treeTable_t  Tree,
    output huff_pkg::nodeId_t     RootRight,
    output huff_pkg::nodeId_t     RootLeft
);

    huff_pkg::nodeId_t     rightId;
    huff_pkg::nodeId_t     leftId;
    huff_pkg::nodeWeight_t rightWeight;
    huff_pkg::nodeWeight_t leftWeight;
    huff_pkg::nodeId_t     entryId;

    // picks of the current merge
    always_ff @(posedge Clk_in)
    begin
        if (TakeRight)
        begin
            rightId     <= Pick.id;
            rightWeight <= Pick.weight;
        end
        if (TakeLeft)
        begin
            leftId     <= Pick.id;
            leftWeight <= Pick.weight;
        end
    end

    assign PickedSum = rightWeight + leftWeight;
    assign entryId   = NewId - huff_pkg::nodeId_t'(`HUFF_NUM_LEAVES); // node 10 -> entry 0

    always_ff @(posedge Clk_in or negedge n_Rst)
    begin
        if (!n_Rst)
        begin
            Tree      <= '0;
            RootRight <= '0;
            RootLeft  <= '0;
        end
        else if (LoadPool)
        begin
            Tree      <= '0;
            RootRight <= '0;
            RootLeft  <= '0;
        end
        else if (WriteNode)
        begin
            if (LastMerge)
            begin
                RootRight <= rightId;
                RootLeft  <= leftId;
            end
            else
            begin
                Tree[entryId[2:0]] <= '{parent: NewId, left: leftId, right: rightId};
            end
        end
    end

endmodule

// ==== src/huffmanTree.sv ====
`include "huff_config.svh"

module huffmanTree (
    input  logic                   Clk_in,
    input  logic                   n_Rst,
    input  logic                   Start,
    input  huff_pkg::leafWeights_t Weights,
    output logic                   Busy,
    output logic                   Done,
    output huff_pkg::treeTable_t   Tree,
    output huff_pkg::nodeId_t      RootRight,
    output huff_pkg::nodeId_t      RootLeft
);

    logic loadPool;
    logic markUsed;
    logic writeNode;
    logic takeRight;
    logic takeLeft;
    logic countClr;
    logic countStep;
    logic lastMerge;

    huff_pkg::nodeId_t                                newId;
    huff_pkg::pick_t                                  pick;
    huff_pkg::nodeWeight_t                            pickedSum;
    huff_pkg::nodeWeight_t [`HUFF_NUM_NODES-1:0]      nodeWeights;
    logic [`HUFF_NUM_NODES-1:0]                       used;

    //////////////////////////////////////////////////////////////////////
    // control

    huffTreeCtrl ctrl (
        .Clk_in    (Clk_in),
        .n_Rst     (n_Rst),
        .Start     (Start),
        .LastMerge (lastMerge),
        .LoadPool  (loadPool),
        .MarkUsed  (markUsed),
        .TakeRight (takeRight),
        .TakeLeft  (takeLeft),
        .WriteNode (writeNode),
        .CountClr  (countClr),
        .CountStep (countStep),
        .Busy      (Busy),
        .Done      (Done)
    );

    mergeCounter counter (
        .Clk_in    (Clk_in),
        .n_Rst     (n_Rst),
        .CountClr  (countClr),
        .CountStep (countStep),
        .NewId     (newId),
        .LastMerge (lastMerge)
    );

    //////////////////////////////////////////////////////////////////////
    // datapath

    weightPool pool (
        .Clk_in      (Clk_in),
        .n_Rst       (n_Rst),
        .LoadPool    (loadPool),
        .MarkUsed    (markUsed),
        .WriteNode   (writeNode),
        .Weights     (Weights),
        .Pick        (pick),
        .NewId       (newId),
        .PickedSum   (pickedSum),
        .NodeWeights (nodeWeights),
        .Used        (used)
    );

    minFinder finder (
        .Weights (nodeWeights),
        .Used    (used),
        .Pick    (pick)
    );

    treeTable table0 (
        .Clk_in    (Clk_in),
        .n_Rst     (n_Rst),
        .LoadPool  (loadPool),
        .TakeRight (takeRight),
        .TakeLeft  (takeLeft),
        .WriteNode (writeNode),
        .Pick      (pick),
        .NewId     (newId),
        .LastMerge (lastMerge),
        .PickedSum (pickedSum),
        .Tree      (Tree),
        .RootRight (RootRight),
        .RootLeft  (RootLeft)
    );

endmodule

// ==== test/huffmanTree_assertions.sv ====
module huffmanTree_assertions (
    input logic Clk_in,
    input logic n_Rst,
    input logic Busy,
    input logic Done,
    input logic TakeRight,
    input logic TakeLeft
);

    timeunit 1ns;
    timeprecision 100ps;

    //////////////////////////////////////////////////////////////////////
    // controller outputs

    doneOneCycle: assert property (@(posedge Clk_in) disable iff (!n_Rst)
        Done |=> !Done)
        else $error("Done stayed high for more than one cycle");

    // Busy drops on the same edge that raises Done
    doneEndsBusy: assert property (@(posedge Clk_in) disable iff (!n_Rst)
        Done |-> (!Busy && $past(Busy)))
        else $error("Done came without Busy falling");

    takeExclusive: assert property (@(posedge Clk_in) disable iff (!n_Rst)
        !(TakeRight && TakeLeft))
        else $error("TakeRight and TakeLeft high in the same cycle");

endmodule

bind huffTreeCtrl huffmanTree_assertions ctrlChecks (
    .Clk_in    (Clk_in),
    .n_Rst     (n_Rst),
    .Busy      (Busy),
    .Done      (Done),
    .TakeRight (TakeRight),
    .TakeLeft  (TakeLeft)
);

// ==== test/huffmanTree_tb.sv ====
`include "huff_config.svh"

module huffmanTree_tb;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int CLK_PERIOD   = 4;
    localparam int RESET_CYCLES = 10;
    localparam int NUM_ROWS     = 12;
    localparam int DONE_EDGE    = 28; // edges after Start until Done
    localparam int RESTART_EDGE = 10;
    localparam int CYCLE_LIMIT  = NUM_ROWS * 40 + 100;

    logic                   Clk_in;
    logic                   n_Rst;
    logic                   Start;
    huff_pkg::leafWeights_t Weights;
    logic                   Busy;
    logic                   Done;
    huff_pkg::treeTable_t   Tree;
    huff_pkg::nodeId_t      RootRight;
    huff_pkg::nodeId_t      RootLeft;

    huff_pkg::leafWeights_t stimTable [NUM_ROWS];
    logic                   restartRow [NUM_ROWS]; // extra Start mid-run
    huff_pkg::treeTable_t   expTree [NUM_ROWS];
    huff_pkg::nodeId_t      expRight [NUM_ROWS];
    huff_pkg::nodeId_t      expLeft [NUM_ROWS];

    int errorCount;
    int checkCount;
    int cycleCount;
    int seed;
    int row;

    huffmanTree UUT (
        .Clk_in    (Clk_in),
        .n_Rst     (n_Rst),
        .Start     (Start),
        .Weights   (Weights),
        .Busy      (Busy),
        .Done      (Done),
        .Tree      (Tree),
        .RootRight (RootRight),
        .RootLeft  (RootLeft)
    );

    initial
    begin
        Clk_in = 1'b0;
        forever #(CLK_PERIOD / 2) Clk_in = ~Clk_in;
    end

    initial
    begin
        cycleCount = 0;
        while (cycleCount < CYCLE_LIMIT)
        begin
            @(posedge Clk_in);
            cycleCount++;
        end
        $display("simulation timed out before all rows ran");
        $display("Some tests failed");
        $finish;
    end

    //////////////////////////////////////////////////////////////////////
    // checks

    task automatic checkLevel(input logic got, input logic exp, input string what);
        checkCount++;
        assert (got === exp) else
        begin
            errorCount++;
            $display("FAIL %0t: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    task automatic compareId(input huff_pkg::nodeId_t got, input huff_pkg::nodeId_t exp,
                             input string what);
        checkCount++;
        assert (got === exp) else
        begin
            errorCount++;
            $display("FAIL %0t: %s is %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic verifyEntry(input int r, input int e, input huff_pkg::treeEntry_t got,
                               input huff_pkg::treeEntry_t exp);
        checkCount++;
        assert (got === exp) else
        begin
            errorCount++;
            $display("FAIL %0t: row %0d entry %0d is {%0d,%0d,%0d}, expected {%0d,%0d,%0d}",
                     $time, r, e, got.parent, got.left, got.right,
                     exp.parent, exp.left, exp.right);
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // reference model picks the smallest first and the lowest id on a tie

    task automatic buildExpected(input huff_pkg::leafWeights_t w,
                                 output huff_pkg::treeTable_t t,
                                 output huff_pkg::nodeId_t rootR,
                                 output huff_pkg::nodeId_t rootL);
        int nodeWt [`HUFF_NUM_NODES + 1];
        bit inPool [`HUFF_NUM_NODES + 1];
        int picked [2];
        int best;
        int newId;
        int i;
        int k;
        int m;
        t     = '0;
        rootR = '0;
        rootL = '0;
        for (i = 0; i <= `HUFF_NUM_NODES; i++)
        begin
            inPool[i] = (i < `HUFF_NUM_LEAVES);
            nodeWt[i] = (i < `HUFF_NUM_LEAVES) ? int'(w.leaf[i]) : 0;
        end
        for (m = 0; m < `HUFF_NUM_MERGES; m++)
        begin
            newId = `HUFF_NUM_LEAVES + m;
            for (k = 0; k < 2; k++) // right first, then left
            begin
                best = -1;
                for (i = 0; i < newId; i++)
                begin
                    if (inPool[i] && (best < 0 || nodeWt[i] < nodeWt[best]))
                        best = i;
                end
                picked[k]    = best;
                inPool[best] = 1'b0;
            end
            if (m < `HUFF_NUM_MERGES - 1)
            begin
                t[m].parent    = huff_pkg::nodeId_t'(newId);
                t[m].left      = huff_pkg::nodeId_t'(picked[1]);
                t[m].right     = huff_pkg::nodeId_t'(picked[0]);
                nodeWt[newId]  = nodeWt[picked[0]] + nodeWt[picked[1]];
                inPool[newId]  = 1'b1;
            end
            else
            begin
                rootR = huff_pkg::nodeId_t'(picked[0]);
                rootL = huff_pkg::nodeId_t'(picked[1]);
            end
        end
    endtask

    task automatic fillTable;
        int r;
        int i;
        for (i = 0; i < `HUFF_NUM_LEAVES; i++)
        begin
            stimTable[0].leaf[i] = 8'd7;   // all equal
            stimTable[1].leaf[i] = 8'd0;
            stimTable[2].leaf[i] = 8'(i + 1);
            stimTable[3].leaf[i] = 8'(10 * (10 - i));
            stimTable[4].leaf[i] = (i == 6) ? 8'd250 : 8'd2; // one dominant
            stimTable[5].leaf[i] = 8'd255; // widest sums
        end
        for (r = 6; r < NUM_ROWS; r++)
        begin
            for (i = 0; i < `HUFF_NUM_LEAVES; i++)
            begin
                stimTable[r].leaf[i] = 8'($random(seed));
                if (r >= 9)
                    stimTable[r].leaf[i] = stimTable[r].leaf[i] & 8'h0f; // force ties
            end
        end
        for (r = 0; r < NUM_ROWS; r++)
        begin
            restartRow[r] = (r == 1) || (r == 9);
            buildExpected(stimTable[r], expTree[r], expRight[r], expLeft[r]);
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // one build from Start to Done

    task automatic applyRow(input int r);
        int edges;
        int e;
        Weights = stimTable[r];
        Start   = 1'b1;
        @(negedge Clk_in);
        Start = 1'b0;
        edges = 0;
        checkLevel(Tree == '0, 1'b1, $sformatf("row %0d Tree cleared at Start", r));
        compareId(RootRight, '0, $sformatf("row %0d RootRight cleared at Start", r));
        compareId(RootLeft, '0, $sformatf("row %0d RootLeft cleared at Start", r));
        while (!Done && edges <= DONE_EDGE)
        begin
            if (edges >= 1)
                checkLevel(Busy, 1'b1, $sformatf("row %0d Busy during build", r));
            Start = restartRow[r] && (edges == RESTART_EDGE);
            if (Start)
                Weights = huff_pkg::leafWeights_t'(~stimTable[r]);
            @(negedge Clk_in);
            edges++;
        end
        checkCount++;
        assert (Done && edges == DONE_EDGE) else
        begin
            errorCount++;
            $display("FAIL %0t: row %0d Done seen %0b after %0d edges, expected %0d",
                     $time, r, Done, edges, DONE_EDGE);
        end
        checkLevel(Busy, 1'b0, $sformatf("row %0d Busy with Done", r));
        for (e = 0; e < `HUFF_NUM_MERGES - 1; e++)
            verifyEntry(r, e, Tree[e], expTree[r][e]);
        compareId(RootRight, expRight[r], $sformatf("row %0d RootRight", r));
        compareId(RootLeft, expLeft[r], $sformatf("row %0d RootLeft", r));
        @(negedge Clk_in);
        checkLevel(Done, 1'b0, $sformatf("row %0d Done one cycle later", r));
        compareId(RootRight, expRight[r], $sformatf("row %0d RootRight held", r));
    endtask

    initial
    begin
        n_Rst      = 1'b0;
        Start      = 1'b0;
        Weights    = '0;
        errorCount = 0;
        checkCount = 0;
        seed       = 32'h5d23_2717;
        fillTable();
        repeat (RESET_CYCLES) @(negedge Clk_in);
        n_Rst = 1'b1;
        @(negedge Clk_in);
        checkLevel(Busy, 1'b0, "Busy after reset");
        checkLevel(Done, 1'b0, "Done after reset");
        checkLevel(Tree == '0, 1'b1, "Tree zero after reset");
        compareId(RootRight, '0, "RootRight after reset");
        compareId(RootLeft, '0, "RootLeft after reset");
        for (row = 0; row < NUM_ROWS; row++)
            applyRow(row);
        $display("checks: %0d, errors: %0d", checkCount, errorCount);
        if (errorCount == 0)
            $display("All tests passed");
        else
            $display("Some tests failed");
        $finish;
    end

endmodule

// ==== files.f ====
+incdir+src
src/huff_pkg.sv
src/huffTreeCtrl.sv
src/mergeCounter.sv
src/weightPool.sv
src/minFinder.sv
src/treeTable.sv
src/huffmanTree.sv
test/huffmanTree_assertions.sv
test/huffmanTree_tb.sv

// ==== run.sh ====
#!/bin/sh
# build the testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --timescale 1ns/100ps \
    -f files.f --top-module huffmanTree_tb -o huffsim \
    && ./obj_dir/huffsim | tee /dev/stderr | grep -q "^All tests passed$" \
    && echo "simulation run: pass" \
    || { echo "simulation run: fail"; exit 1; }
